/* page_mmu.f */
+incdir+logic
logic/page_mmu_pkg.sv
logic/page_translator.sv
logic/page_attr_ram.sv
logic/fill_sequencer.sv
logic/fill_counter.sv
logic/bus_issuer.sv
logic/page_mmu.sv
tb/page_mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the page MMU testbench with Verilator and runs it.
# Exits nonzero when the log shows a failure or no pass.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f page_mmu.f --top-module page_mmu_tb -o page_mmu_sim

./obj_dir/page_mmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log

/* tb/page_mmu_tb.sv */
/*
 * Self-checking testbench for the page MMU. A table of map writes,
 * attribute accesses, requests, credit returns and fills is applied
 * in order, each step checked against the expected values it carries.
 */

`include "page_mmu_consts.svh"

module page_mmu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 100;
    localparam int READY_TIMEOUT = 20;      // Cycles allowed for o_req_ready
    localparam int FILL_TIMEOUT  = 2000;    // Cycles allowed for a fill

    localparam page_mmu_pkg::bus_op_t CCRD  = page_mmu_pkg::CCRD;
    localparam page_mmu_pkg::bus_op_t DCRD  = page_mmu_pkg::DCRD;
    localparam page_mmu_pkg::bus_op_t DRD   = page_mmu_pkg::DRD;
    localparam page_mmu_pkg::bus_op_t DWR   = page_mmu_pkg::DWR;
    localparam page_mmu_pkg::bus_op_t RDMWR = page_mmu_pkg::RDMWR;

    typedef enum logic [2:0] {
        STEP_MAP,       // Map write page -> ppage
        STEP_ATTR_WR,   // Host write of bits
        STEP_ATTR_CHK,  // Readback of bits
        STEP_REQ,       // Request, credit returned afterwards
        STEP_REQ_HOLD,  // Request, credit kept by memory side
        STEP_STALL,     // Valid held, ready must stay low
        STEP_CREDIT,    // One credit pulse
        STEP_FILL       // Reprio fill
    } step_kind_t;

    typedef struct packed {
        step_kind_t            kind;
        page_mmu_pkg::vaddr_t  vaddr;   // Offset bits filled in at random
        page_mmu_pkg::bus_op_t op;
        logic                  besm6;
        logic                  no_paging;
        page_mmu_pkg::page_t   page;    // Map vpage or attribute page
        page_mmu_pkg::page_t   ppage;   // Map ppage or expected physical page
        logic [2:0]            bits;    // Used, dirty, reprio
    } step_t;

    logic clk, reset;
    logic i_req_valid, o_req_ready, i_besm6_mode, i_no_paging;
    page_mmu_pkg::vaddr_t  i_req_vaddr;
    page_mmu_pkg::bus_op_t i_req_op, o_bus_op;
    page_mmu_pkg::physad_t o_bus_physad;
    logic o_bus_valid, i_bus_credit, i_map_we;
    page_mmu_pkg::page_t i_map_vpage, i_map_ppage, i_attr_page;
    logic i_attr_we, i_attr_used, i_attr_dirty, i_attr_reprio;
    logic o_attr_used, o_attr_dirty, o_attr_reprio, i_fill_start, o_fill_busy;

    step_t  steps[$];
    integer seed   = 32'h819a;

    page_mmu page_mmu_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------
    // Step drivers
    // ------------------------------
    function automatic void add_step(step_kind_t kind, page_mmu_pkg::vaddr_t vaddr,
                                     page_mmu_pkg::bus_op_t op, logic besm6,
                                     logic no_paging, page_mmu_pkg::page_t page,
                                     page_mmu_pkg::page_t ppage, logic [2:0] bits);
        step_t s;
        s = '{kind, vaddr, op, besm6, no_paging, page, ppage, bits};
        steps.push_back(s);
    endfunction

    task automatic pulse_credit();
        @(negedge clk);
        i_bus_credit = 1'b1;
        @(negedge clk);
        i_bus_credit = 1'b0;
    endtask

    task automatic drive_request(input step_t s, input bit give_back);
        logic [9:0] offset;
        int         waited;
        offset = 10'($random(seed));
        @(negedge clk);
        i_req_valid  = 1'b1;
        i_req_vaddr  = s.vaddr | {22'b0, offset};
        i_req_op     = s.op;
        i_besm6_mode = s.besm6;
        i_no_paging  = s.no_paging;
        waited = 0;
        while (!o_req_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_req_ready) begin
            $display("TIMEOUT at %0t ns: o_req_ready never went high", $time);
            abort_run();
        end
        @(negedge clk);                     // Accepted at the edge just passed
        i_req_valid = 1'b0;
        check_value("o_bus_valid", 32'(o_bus_valid), 32'd1);
        check_value("o_bus_physad", 32'(o_bus_physad), 32'({s.ppage, offset}));
        check_value("o_bus_op", 32'(o_bus_op), 32'(s.op));
        @(negedge clk);
        check_value("o_bus_valid", 32'(o_bus_valid), 32'd0);   // One cycle only
        if (give_back) begin
            pulse_credit();
        end
    endtask

    task automatic check_stall();
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req_vaddr = '0;
        repeat (4) begin
            check_value("o_req_ready", 32'(o_req_ready), 32'd0);
            check_value("o_bus_valid", 32'(o_bus_valid), 32'd0);
            @(negedge clk);
        end
        i_req_valid = 1'b0;
    endtask

    task automatic run_fill();
        int busy_cycles;
        @(negedge clk);
        i_fill_start = 1'b1;
        @(negedge clk);
        i_fill_start = 1'b0;
        check_value("o_fill_busy", 32'(o_fill_busy), 32'd1);
        busy_cycles = 0;
        while (o_fill_busy && busy_cycles < FILL_TIMEOUT) begin
            check_value("o_req_ready", 32'(o_req_ready), 32'd0);
            busy_cycles++;
            i_fill_start = (busy_cycles == 500);    // Restart attempt mid fill
            @(negedge clk);
        end
        i_fill_start = 1'b0;
        if (o_fill_busy) begin
            $display("TIMEOUT at %0t ns: o_fill_busy never fell after a fill", $time);
            abort_run();
        end
        check_value("fill busy cycles", 32'(busy_cycles), 32'(`MMU_PAGE_COUNT));
    endtask

    task automatic apply_step(input step_t s);
        case (s.kind)
            STEP_MAP: begin
                @(negedge clk);
                {i_map_we, i_map_vpage, i_map_ppage} = {1'b1, s.page, s.ppage};
                @(negedge clk);
                i_map_we = 1'b0;
            end
            STEP_ATTR_WR: begin
                @(negedge clk);
                i_attr_page = s.page;
                i_attr_we   = 1'b1;
                {i_attr_used, i_attr_dirty, i_attr_reprio} = s.bits;
                @(negedge clk);
                i_attr_we = 1'b0;
            end
            STEP_ATTR_CHK: begin
                @(negedge clk);
                i_attr_page = s.page;
                #(CLK_PERIOD / 4);                  // Readback settles
                check_value("o_attr_used", 32'(o_attr_used), 32'(s.bits[2]));
                check_value("o_attr_dirty", 32'(o_attr_dirty), 32'(s.bits[1]));
                check_value("o_attr_reprio", 32'(o_attr_reprio), 32'(s.bits[0]));
            end
            STEP_REQ:      drive_request(s, 1'b1);
            STEP_REQ_HOLD: drive_request(s, 1'b0);
            STEP_STALL:    check_stall();
            STEP_CREDIT:   pulse_credit();
            STEP_FILL:     run_fill();
        endcase
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    function automatic void load_table();
        add_step(STEP_MAP,      32'h0,         DRD,   1'b0, 1'b0, 10'h005, 10'h2A5, 3'b000);
        add_step(STEP_MAP,      32'h0,         DRD,   1'b0, 1'b0, 10'h123, 10'h0F0, 3'b000);
        add_step(STEP_MAP,      32'h0,         DRD,   1'b0, 1'b0, 10'h003, 10'h155, 3'b000);
        add_step(STEP_MAP,      32'h0,         DRD,   1'b0, 1'b0, 10'h3FF, 10'h001, 3'b000);
        add_step(STEP_REQ,      32'h0000_1400, DRD,   1'b0, 1'b0, 10'h000, 10'h2A5, 3'b000);
        add_step(STEP_REQ,      32'h0004_8C00, DCRD,  1'b0, 1'b0, 10'h000, 10'h0F0, 3'b000);
        add_step(STEP_REQ,      32'hABCF_FC00, CCRD,  1'b0, 1'b0, 10'h000, 10'h001, 3'b000);
        // Bypass and BESM-6 page selection
        add_step(STEP_REQ,      32'h000B_5800, DRD,   1'b0, 1'b1, 10'h000, 10'h2D6, 3'b000);
        add_step(STEP_REQ,      32'h0000_0C00, DRD,   1'b1, 1'b0, 10'h000, 10'h155, 3'b000);
        add_step(STEP_REQ,      32'h000F_8C00, DRD,   1'b1, 1'b0, 10'h000, 10'h155, 3'b000);
        add_step(STEP_REQ,      32'h0005_1400, DRD,   1'b1, 1'b0, 10'h000, 10'h2A5, 3'b000);
        add_step(STEP_REQ,      32'h0005_1400, DRD,   1'b1, 1'b1, 10'h000, 10'h005, 3'b000);
        // Access marking
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h2A5, 10'h000, 3'b000);
        add_step(STEP_REQ,      32'h0000_1400, DRD,   1'b0, 1'b0, 10'h000, 10'h2A5, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h2A5, 10'h000, 3'b100);
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h0F0, 10'h000, 3'b000);
        add_step(STEP_REQ,      32'h0004_8C00, DWR,   1'b0, 1'b0, 10'h000, 10'h0F0, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h0F0, 10'h000, 3'b110);
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h155, 10'h000, 3'b000);
        add_step(STEP_REQ,      32'h0000_0C00, RDMWR, 1'b1, 1'b0, 10'h000, 10'h155, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h155, 10'h000, 3'b110);
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h001, 10'h000, 3'b001);
        add_step(STEP_REQ,      32'h000F_FC00, CCRD,  1'b0, 1'b0, 10'h000, 10'h001, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h001, 10'h000, 3'b101);
        // Reprio fill over sampled pages
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b100);
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h200, 10'h000, 3'b010);
        add_step(STEP_ATTR_WR,  32'h0,         DRD,   1'b0, 1'b0, 10'h3FF, 10'h000, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b100);
        add_step(STEP_FILL,     32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b000);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b101);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h200, 10'h000, 3'b011);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h3FF, 10'h000, 3'b001);
        add_step(STEP_ATTR_CHK, 32'h0,         DRD,   1'b0, 1'b0, 10'h155, 10'h000, 3'b111);
        add_step(STEP_REQ,      32'h0000_1400, DRD,   1'b0, 1'b0, 10'h000, 10'h2A5, 3'b000);
        // Credit exhaustion and one returned credit
        add_step(STEP_REQ_HOLD, 32'h0000_4000, DRD,   1'b0, 1'b1, 10'h000, 10'h010, 3'b000);
        add_step(STEP_REQ_HOLD, 32'h0000_4400, DWR,   1'b0, 1'b1, 10'h000, 10'h011, 3'b000);
        add_step(STEP_REQ_HOLD, 32'h0000_4800, DRD,   1'b0, 1'b1, 10'h000, 10'h012, 3'b000);
        add_step(STEP_REQ_HOLD, 32'h0000_4C00, DCRD,  1'b0, 1'b1, 10'h000, 10'h013, 3'b000);
        add_step(STEP_STALL,    32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b000);
        add_step(STEP_CREDIT,   32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b000);
        add_step(STEP_REQ_HOLD, 32'h0000_5000, DRD,   1'b0, 1'b1, 10'h000, 10'h014, 3'b000);
        add_step(STEP_STALL,    32'h0,         DRD,   1'b0, 1'b0, 10'h000, 10'h000, 3'b000);
    endfunction

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        reset        = 1'b1;
        i_req_valid  = 1'b0;
        i_req_vaddr  = '0;
        i_req_op     = DRD;
        i_besm6_mode = 1'b0;
        i_no_paging  = 1'b0;
        i_bus_credit = 1'b0;
        i_map_we     = 1'b0;
        i_map_vpage  = '0;
        i_map_ppage  = '0;
        i_attr_page  = '0;
        i_attr_we    = 1'b0;
        {i_attr_used, i_attr_dirty, i_attr_reprio} = 3'b000;
        i_fill_start = 1'b0;
        load_table();
        repeat (2) @(negedge clk);          // Two rising edges in reset
        reset = 1'b0;
        @(negedge clk);
        check_value("o_bus_valid", 32'(o_bus_valid), 32'd0);
        check_value("o_fill_busy", 32'(o_fill_busy), 32'd0);
        check_value("o_req_ready", 32'(o_req_ready), 32'd1);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* logic/page_mmu.sv */
/*
 * Page MMU top level. Translates requests through the page map,
 * marks page attributes, runs the reprioritize fill and issues
 * physical requests to the memory side under credit control.
 */

module page_mmu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_req_valid,     // Request side
    input  page_mmu_pkg::vaddr_t  i_req_vaddr,
    input  page_mmu_pkg::bus_op_t i_req_op,
    output logic                  o_req_ready,
    input  logic                  i_besm6_mode,    // Short virtual page
    input  logic                  i_no_paging,     // Map bypass
    output logic                  o_bus_valid,     // Memory side
    output page_mmu_pkg::physad_t o_bus_physad,
    output page_mmu_pkg::bus_op_t o_bus_op,
    input  logic                  i_bus_credit,
    input  logic                  i_map_we,        // Map write
    input  page_mmu_pkg::page_t   i_map_vpage,
    input  page_mmu_pkg::page_t   i_map_ppage,
    input  page_mmu_pkg::page_t   i_attr_page,     // Attribute access
    input  logic                  i_attr_we,
    input  logic                  i_attr_used,
    input  logic                  i_attr_dirty,
    input  logic                  i_attr_reprio,
    output logic                  o_attr_used,
    output logic                  o_attr_dirty,
    output logic                  o_attr_reprio,
    input  logic                  i_fill_start,    // Reprio fill
    output logic                  o_fill_busy
);

    page_mmu_pkg::physad_t physad;      // Translated request address
    logic                  mark;        // Access marking strobe
    page_mmu_pkg::page_t   mark_page;
    logic                  mark_dirty;
    page_mmu_pkg::page_t   fill_page;   // Page under fill
    logic                  last_page;
    logic                  count_clear;
    logic                  count_en;

    // ------------------------------
    // Translation and attributes
    // ------------------------------
    page_translator translator_inst (
        .clk          (clk),
        .i_map_we     (i_map_we),
        .i_map_vpage  (i_map_vpage),
        .i_map_ppage  (i_map_ppage),
        .i_vaddr      (i_req_vaddr),
        .i_besm6_mode (i_besm6_mode),
        .i_no_paging  (i_no_paging),
        .o_physad     (physad)
    );

    page_attr_ram attr_ram_inst (
        .clk           (clk),
        .i_mark        (mark),
        .i_mark_page   (mark_page),
        .i_mark_dirty  (mark_dirty),
        .i_fill_we     (o_fill_busy),   // One page written per busy cycle
        .i_fill_page   (fill_page),
        .i_attr_page   (i_attr_page),
        .i_attr_we     (i_attr_we),
        .i_attr_used   (i_attr_used),
        .i_attr_dirty  (i_attr_dirty),
        .i_attr_reprio (i_attr_reprio),
        .o_attr_used   (o_attr_used),
        .o_attr_dirty  (o_attr_dirty),
        .o_attr_reprio (o_attr_reprio)
    );

    // ------------------------------
    // Fill control
    // ------------------------------
    fill_sequencer sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .i_fill_start  (i_fill_start),
        .i_last_page   (last_page),
        .o_fill_busy   (o_fill_busy),
        .o_count_clear (count_clear),
        .o_count_en    (count_en)
    );

    fill_counter counter_inst (
        .clk         (clk),
        .i_clear     (count_clear),
        .i_en        (count_en),
        .o_page      (fill_page),
        .o_last_page (last_page)
    );

    bus_issuer issuer_inst (
        .clk          (clk),
        .reset        (reset),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_physad     (physad),
        .i_fill_busy  (o_fill_busy),
        .i_bus_credit (i_bus_credit),
        .o_req_ready  (o_req_ready),
        .o_bus_valid  (o_bus_valid),
        .o_bus_physad (o_bus_physad),
        .o_bus_op     (o_bus_op),
        .o_mark       (mark),
        .o_mark_page  (mark_page),
        .o_mark_dirty (mark_dirty)
    );

endmodule

/* logic/bus_issuer.sv */
/*
 * Request acceptance and memory-side issue. Holds the credit count,
 * registers each accepted request for one cycle of o_bus_valid and
 * drives access marking for the translated page.
 */

`include "page_mmu_consts.svh"

module bus_issuer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_req_valid,
    input  page_mmu_pkg::bus_op_t i_req_op,
    input  page_mmu_pkg::physad_t i_physad,     // Translated i_req_vaddr
    input  logic                  i_fill_busy,
    input  logic                  i_bus_credit, // One credit back
    output logic                  o_req_ready,
    output logic                  o_bus_valid,
    output page_mmu_pkg::physad_t o_bus_physad,
    output page_mmu_pkg::bus_op_t o_bus_op,
    output logic                  o_mark,
    output page_mmu_pkg::page_t   o_mark_page,
    output logic                  o_mark_dirty
);

    page_mmu_pkg::credit_t credits;         // Credits not yet spent on the bus
    page_mmu_pkg::credit_t avail_credits;   // Minus the request on the bus now
    logic                  accept;
    logic                  write_op;

    // ------------------------------
    // Credit accounting
    // ------------------------------
    assign avail_credits = credits - page_mmu_pkg::credit_t'(o_bus_valid);
    assign o_req_ready   = (avail_credits != '0) && !i_fill_busy;
    assign accept        = i_req_valid && o_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= page_mmu_pkg::credit_t'(`MMU_BUS_CREDITS);
        end else begin
            credits <= avail_credits + page_mmu_pkg::credit_t'(i_bus_credit);
        end
    end

    // ------------------------------
    // Outgoing request
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_bus_valid <= 1'b0;
        end else begin
            o_bus_valid <= accept;          // One cycle per request
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_bus_physad <= i_physad;
            o_bus_op     <= i_req_op;
        end
    end

    // ------------------------------
    // Access marking
    // ------------------------------
    always_comb begin
        case (i_req_op)
            page_mmu_pkg::CCWR,
            page_mmu_pkg::DCWR,
            page_mmu_pkg::DWR,
            page_mmu_pkg::RDMWR,
            page_mmu_pkg::BTRWR: write_op = 1'b1;   // Page gets modified
            default:             write_op = 1'b0;
        endcase
    end

    assign o_mark       = accept;
    assign o_mark_page  = i_physad[`MMU_OFFSET_BITS +: `MMU_PAGE_BITS];
    assign o_mark_dirty = write_op;

    a_credit_limit : assert property (
        @(posedge clk) disable iff (reset) credits <= page_mmu_pkg::credit_t'(`MMU_BUS_CREDITS)
    ) else $error("credit count above limit");

    a_valid_has_credit : assert property (
        @(posedge clk) disable iff (reset) o_bus_valid |-> credits != '0
    ) else $error("bus request issued without a credit");

endmodule

/* logic/fill_counter.sv */
/*
 * Page counter for the reprioritize fill. Cleared at fill start,
 * advanced once per page, flags the last page of the map.
 */

`include "page_mmu_consts.svh"

module fill_counter (
    input  logic                clk,
    input  logic                i_clear,
    input  logic                i_en,
    output page_mmu_pkg::page_t o_page,
    output logic                o_last_page
);

    page_mmu_pkg::page_t page_cnt;

    always_ff @(posedge clk) begin
        if (i_clear) begin
            page_cnt <= '0;                 // Start at page 0
        end else if (i_en) begin
            page_cnt <= page_cnt + 1'b1;
        end
    end

    assign o_page      = page_cnt;
    assign o_last_page = (page_cnt == page_mmu_pkg::page_t'(`MMU_PAGE_COUNT - 1));

endmodule

/* logic/fill_sequencer.sv */
/*
 * State machine for the reprioritize fill. A start pulse clears
 * the page counter and runs until the counter flags the last page.
 * Start pulses during a fill are ignored.
 */

module fill_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic i_fill_start,
    input  logic i_last_page,
    output logic o_fill_busy,
    output logic o_count_clear,
    output logic o_count_en
);

    page_mmu_pkg::fill_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= page_mmu_pkg::FILL_IDLE;
        end else begin
            case (state)
                page_mmu_pkg::FILL_IDLE: begin
                    if (i_fill_start) begin
                        state <= page_mmu_pkg::FILL_RUN;
                    end
                end
                page_mmu_pkg::FILL_RUN: begin
                    if (i_last_page) begin
                        state <= page_mmu_pkg::FILL_IDLE;  // Last page written now
                    end
                end
                default: state <= page_mmu_pkg::FILL_IDLE;
            endcase
        end
    end

    assign o_fill_busy   = (state == page_mmu_pkg::FILL_RUN);
    assign o_count_clear = i_fill_start && (state == page_mmu_pkg::FILL_IDLE);
    assign o_count_en    = (state == page_mmu_pkg::FILL_RUN) && !i_last_page;  // Hold at end

    a_count_in_run : assert property (
        @(posedge clk) disable iff (reset) o_count_en |-> state == page_mmu_pkg::FILL_RUN
    ) else $error("fill counter enabled outside FILL_RUN");

endmodule

/* logic/page_attr_ram.sv */
/*
 * Per-page used, dirty and reprioritize bits. Written by the fill
 * walk, by the host port and by access marking, in that priority.
 * The selected page's bits read back combinationally.
 */

`include "page_mmu_consts.svh"

module page_attr_ram (
    input  logic                clk,
    input  logic                i_mark,         // Access marking
    input  page_mmu_pkg::page_t i_mark_page,
    input  logic                i_mark_dirty,
    input  logic                i_fill_we,      // Fill walk
    input  page_mmu_pkg::page_t i_fill_page,
    input  page_mmu_pkg::page_t i_attr_page,    // Host port
    input  logic                i_attr_we,
    input  logic                i_attr_used,
    input  logic                i_attr_dirty,
    input  logic                i_attr_reprio,
    output logic                o_attr_used,
    output logic                o_attr_dirty,
    output logic                o_attr_reprio
);

    logic used_bits   [`MMU_PAGE_COUNT];    // Page referenced
    logic dirty_bits  [`MMU_PAGE_COUNT];    // Page modified
    logic reprio_bits [`MMU_PAGE_COUNT];    // Reprioritize request

    // ------------------------------
    // Write ports
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_fill_we) begin
            reprio_bits[i_fill_page] <= 1'b1;       // Fill sets, never clears
        end else if (i_attr_we) begin
            used_bits[i_attr_page]   <= i_attr_used;
            dirty_bits[i_attr_page]  <= i_attr_dirty;
            reprio_bits[i_attr_page] <= i_attr_reprio;
        end else if (i_mark) begin
            used_bits[i_mark_page] <= 1'b1;         // Every access
            if (i_mark_dirty) begin
                dirty_bits[i_mark_page] <= 1'b1;    // Write-type access
            end
        end
    end

    // ------------------------------
    // Readback
    // ------------------------------
    assign o_attr_used   = used_bits[i_attr_page];
    assign o_attr_dirty  = dirty_bits[i_attr_page];
    assign o_attr_reprio = reprio_bits[i_attr_page];

    // Issuer holds off requests for the whole fill, so no mark is lost
    a_no_mark_in_fill : assert property (
        @(posedge clk) i_fill_we |-> !i_mark
    ) else $error("access mark during reprio fill");

endmodule

/* logic/page_translator.sv */
/*
 * Page map and virtual-to-physical translation. Map entries are
 * written on i_map_we; translation of i_vaddr is combinational.
 */

`include "page_mmu_consts.svh"

module page_translator (
    input  logic                  clk,
    input  logic                  i_map_we,
    input  page_mmu_pkg::page_t   i_map_vpage,
    input  page_mmu_pkg::page_t   i_map_ppage,
    input  page_mmu_pkg::vaddr_t  i_vaddr,
    input  logic                  i_besm6_mode,
    input  logic                  i_no_paging,
    output page_mmu_pkg::physad_t o_physad
);

    page_mmu_pkg::page_t page_map [`MMU_PAGE_COUNT];   // Virtual to physical page
    page_mmu_pkg::page_t virt_page;
    page_mmu_pkg::page_t phys_page;

    // ------------------------------
    // Map write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_map_we) begin
            page_map[i_map_vpage] <= i_map_ppage;   // Visible next cycle
        end
    end

    // ------------------------------
    // Translation
    // ------------------------------
    always_comb begin
        if (i_besm6_mode) begin
            // Only bits 14..10 select a page, upper bits ignored
            virt_page = page_mmu_pkg::page_t'(
                i_vaddr[`MMU_OFFSET_BITS +: `MMU_BESM6_PAGE_BITS]);
        end else begin
            virt_page = i_vaddr[`MMU_OFFSET_BITS +: `MMU_PAGE_BITS];   // Bits 19..10
        end
    end

    always_comb begin
        if (i_no_paging) begin
            phys_page = virt_page;          // Identity mapping
        end else begin
            phys_page = page_map[virt_page];
        end
    end

    assign o_physad = {phys_page, i_vaddr[`MMU_OFFSET_BITS-1:0]};   // Page, word offset

endmodule

/* logic/page_mmu_pkg.sv */
/*
 * Shared types of the page MMU: address vectors, credit count,
 * memory bus opcodes and the fill state machine encoding.
 */

`include "page_mmu_consts.svh"

package page_mmu_pkg;

    typedef logic [31:0] vaddr_t;                                       // Virtual address
    typedef logic [`MMU_PAGE_BITS+`MMU_OFFSET_BITS-1:0] physad_t;       // Physical address
    typedef logic [`MMU_PAGE_BITS-1:0] page_t;                          // Page index
    typedef logic [$clog2(`MMU_BUS_CREDITS+1)-1:0] credit_t;            // Credit count

    // Arbiter opcodes as seen on the memory side
    typedef enum logic [3:0] {
        CCRD  = 4'd1,       // Instruction cache read
        CCWR  = 4'd2,       // Instruction cache write
        DCRD  = 4'd3,       // Data cache read
        DCWR  = 4'd4,       // Data cache write
        DRD   = 4'd9,       // Operand read
        DWR   = 4'd10,      // Result write
        RDMWR = 4'd11,      // Read-modify-write
        BTRWR = 4'd12       // Block transfer write
    } bus_op_t;

    typedef enum logic {
        FILL_IDLE = 1'b0,
        FILL_RUN  = 1'b1    // Walking all pages
    } fill_state_t;

endpackage

/* logic/page_mmu_consts.svh */
/*
 * Size constants for the page MMU.
 * Included by the package and by every module that sizes arrays,
 * counters or address fields.
 */

`ifndef PAGE_MMU_CONSTS_SVH
`define PAGE_MMU_CONSTS_SVH

// ------------------------------
// Page map geometry
// ------------------------------
`define MMU_PAGE_COUNT      1024    // Pages in map and attribute arrays
`define MMU_PAGE_BITS       10      // Page index width
`define MMU_OFFSET_BITS     10      // In-page word offset
`define MMU_BESM6_PAGE_BITS 5       // Virtual page width in BESM-6 mode

// ------------------------------
// Memory side flow control
// ------------------------------
`define MMU_BUS_CREDITS     4       // Credits held after reset

`endif
